// ==== logic/hamming_config.svh ====
// width and pipeline depth macros for the Hamming(31,26) codec

`ifndef HAMMING_CONFIG_SVH
`define HAMMING_CONFIG_SVH

// data bits carried by one codeword
`define HAM_DATA_W 26

// full codeword, position p lives in bit p-1
`define HAM_CODE_W 31

// parity bits at positions 1, 2, 4, 8, 16
// also the width of the syndrome
`define HAM_PARITY_W 5

// register stages on both the encode and the decode path
`define HAM_LATENCY 3

`endif

// ==== logic/hamming_pkg.sv ====
// hamming_pkg: codeword and syndrome types, data scatter and gather, parity masks

package hamming_pkg;

    `include "hamming_config.svh"

    typedef logic [`HAM_DATA_W-1:0] data_word_t;

    // bit p-1 holds position p
    typedef logic [`HAM_CODE_W-1:0] codeword_t;

    // zero for a clean word, else the position of the bad bit
    typedef logic [`HAM_PARITY_W-1:0] syndrome_t;

    // positions 1, 2, 4, 8, 16 carry parity
    function automatic logic is_parity_pos(input int unsigned pos);
        return (pos & (pos - 1)) == 0;
    endfunction

    // data bits go to the non-parity positions, lowest first
    function automatic codeword_t scatter_data(input data_word_t data);
        codeword_t   word;
        int unsigned k;
        word = '0;
        k = 0;
        for (int unsigned pos = 1; pos <= `HAM_CODE_W; pos++) begin
            if (!is_parity_pos(pos)) begin
                word[pos-1] = data[k];
                k++;
            end
        end
        return word;
    endfunction

    // inverse of scatter_data, parity positions are skipped
    function automatic data_word_t gather_data(input codeword_t word);
        data_word_t  data;
        int unsigned k;
        data = '0;
        k = 0;
        for (int unsigned pos = 1; pos <= `HAM_CODE_W; pos++) begin
            if (!is_parity_pos(pos)) begin
                data[k] = word[pos-1];
                k++;
            end
        end
        return data;
    endfunction

    // positions whose number has bit idx set
    // idx 0 gives 1,3,5,.. and idx 4 gives 16..31
    function automatic codeword_t parity_mask(input int unsigned idx);
        codeword_t mask;
        mask = '0;
        for (int unsigned pos = 1; pos <= `HAM_CODE_W; pos++) begin
            mask[pos-1] = ((pos >> idx) & 1) != 0;
        end
        return mask;
    endfunction

endpackage

// ==== logic/codec_status_pkg.sv ====
// codec_status_pkg: decoder result record

package codec_status_pkg;

    `include "hamming_config.svh"

    import hamming_pkg::*;

    // one decoded word as it leaves the last decoder stage
    //   data       corrected payload
    //   corrected  a single bit was flipped back
    //   error_pos  position of that bit, zero if none
    typedef struct packed {
        data_word_t data;
        logic       corrected;
        syndrome_t  error_pos;
    } decode_result_t;

endpackage

// ==== logic/hamming_syndrome.sv ====
// hamming_syndrome: combinational parity check giving the 5-bit syndrome

`timescale 1ns/10ps

`include "hamming_config.svh"

module hamming_syndrome
    import hamming_pkg::*;
(
    input  codeword_t codeword,
    output syndrome_t syndrome
);

    // each check covers its own parity bit as well as the data,
    // so a clean word gives all zeros
    //
    // with one bit flipped at position p, exactly the checks
    // whose mask holds p fail, and their index bits spell p

    always_comb begin
        syndrome = '0;
        for (int i = 0; i < `HAM_PARITY_W; i++) begin
            syndrome[i] = ^(codeword & parity_mask(i));
        end
    end

endmodule

// ==== logic/hamming_encoder.sv ====
// hamming_encoder: three-stage Hamming(31,26) encoder pipeline

`timescale 1ns/10ps

`include "hamming_config.svh"

module hamming_encoder
    import hamming_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  data_word_t data_in,
    output codeword_t  encoded_out
);

    // stage 1, data in place with parity bits still zero
    codeword_t stage1_word;

    // stage 2, parity bits filled in
    codeword_t stage2_word;

    // stage-1 word with parity merged, feeds stage 2
    codeword_t parity_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage1_word <= '0;
        end else begin
            stage1_word <= scatter_data(data_in);
        end
    end

    // parity bit i sits at position 2^i
    // its own slot is zero in stage1_word, so it drops out of the XOR
    always_comb begin
        parity_word = stage1_word;
        for (int i = 0; i < `HAM_PARITY_W; i++) begin
            parity_word[(1 << i) - 1] = ^(stage1_word & parity_mask(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage2_word <= '0;
        end else begin
            stage2_word <= parity_word;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (reset) begin
            encoded_out <= '0;
        end else begin
            encoded_out <= stage2_word;
        end
    end

endmodule

// ==== logic/hamming_decoder.sv ====
// hamming_decoder: three-stage Hamming(31,26) decoder with single-bit correction

`timescale 1ns/10ps

`include "hamming_config.svh"

module hamming_decoder
    import hamming_pkg::*, codec_status_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  codeword_t      received_in,
    output decode_result_t result
);

    // syndrome of the incoming word, ahead of stage 1
    syndrome_t in_syndrome;

    // stage 1, raw word and its syndrome
    codeword_t stage1_word;
    syndrome_t stage1_syndrome;

    // stage 2, corrected word
    codeword_t stage2_word;
    syndrome_t stage2_syndrome;
    logic      stage2_corrected;

    // stage-1 word with the named bit inverted
    codeword_t fixed_word;
    logic      has_error;

    hamming_syndrome i_hamming_syndrome (
        .codeword (received_in),
        .syndrome (in_syndrome)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            stage1_word     <= '0;
            stage1_syndrome <= '0;
        end else begin
            stage1_word     <= received_in;
            stage1_syndrome <= in_syndrome;
        end
    end

    // syndrome is the 1-based position, hence the -1
    always_comb begin
        has_error  = stage1_syndrome != '0;
        fixed_word = stage1_word;
        if (has_error) begin
            fixed_word[stage1_syndrome - 1'b1] = ~stage1_word[stage1_syndrome - 1'b1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage2_word      <= '0;
            stage2_syndrome  <= '0;
            stage2_corrected <= 1'b0;
        end else begin
            stage2_word      <= fixed_word;
            stage2_syndrome  <= stage1_syndrome;
            stage2_corrected <= has_error;
        end
    end

    // stage 3, pull the data bits out and build the record
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result.data      <= gather_data(stage2_word);
            result.corrected <= stage2_corrected;
            result.error_pos <= stage2_syndrome;
        end
    end

endmodule

// ==== logic/hamming_codec_top.sv ====
// hamming_codec_top: Hamming(31,26) encoder and decoder side by side

`timescale 1ns/10ps

module hamming_codec_top
    import hamming_pkg::*, codec_status_pkg::*;
(
    input  logic           clk,
    input  logic           reset,

    // encode path
    input  data_word_t     data_in,
    output codeword_t      encoded_out,

    // decode path, independent of the encoder
    input  codeword_t      received_in,
    output decode_result_t result
);

    // both paths are free running, one word per clock,
    // and each has the same three-cycle latency

    hamming_encoder i_hamming_encoder (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .encoded_out (encoded_out)
    );

    hamming_decoder i_hamming_decoder (
        .clk         (clk),
        .reset       (reset),
        .received_in (received_in),
        .result      (result)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// tb_clock_gen: 4 ns clock and a two-cycle synchronous reset for the testbench

`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held over two rising edges, released on the second one
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== testbench/hamming_codec_checker.sv ====
// hamming_codec_checker: bound concurrent assertions on the codec outputs

`timescale 1ns/10ps

`include "hamming_config.svh"

module hamming_codec_checker
    import hamming_pkg::*, codec_status_pkg::*;
(
    input logic           clk,
    input logic           reset,
    input codeword_t      encoded_out,
    input decode_result_t result
);

    // read by the testbench at the end of the run
    int assert_failures = 0;

    // check bit i covers every position whose number has bit i set
    function automatic syndrome_t word_syndrome(input codeword_t word);
        syndrome_t syn;
        syn = '0;
        for (int i = 0; i < `HAM_PARITY_W; i++) begin
            for (int p = 1; p <= `HAM_CODE_W; p++) begin
                if (((p >> i) & 1) != 0 && word[p-1]) begin
                    syn[i] = ~syn[i];
                end
            end
        end
        return syn;
    endfunction

    encoded_is_codeword: assert property (
        @(posedge clk) disable iff (reset) word_syndrome(encoded_out) == '0
    ) else begin
        $error("encoded_out %h is not a valid codeword", encoded_out);
        assert_failures++;
    end

    corrected_matches_pos: assert property (
        @(posedge clk) disable iff (reset) result.corrected == (result.error_pos != '0)
    ) else begin
        $error("corrected %b disagrees with error_pos %h", result.corrected, result.error_pos);
        assert_failures++;
    end

    reset_clears_outputs: assert property (
        @(posedge clk) reset |=> (encoded_out == '0 && result == '0)
    ) else begin
        $error("outputs not cleared one cycle into reset");
        assert_failures++;
    end

endmodule

bind hamming_codec_top hamming_codec_checker i_codec_checker (
    .clk         (clk),
    .reset       (reset),
    .encoded_out (encoded_out),
    .result      (result)
);

// ==== testbench/hamming_codec_tb.sv ====
// table-driven testbench with reference encoder, checks and watchdog

`timescale 1ns/10ps

`include "hamming_config.svh"

module hamming_codec_tb
    import hamming_pkg::*, codec_status_pkg::*;
();

    localparam int SEED          = 34831;
    localparam int CLK_PERIOD_NS = 4;
    localparam int N_FIXED       = 8;
    localparam int N_SWEEP       = `HAM_CODE_W;
    localparam int N_STREAM      = 64;
    localparam int TABLE_LEN     = N_FIXED + N_SWEEP + N_STREAM;
    localparam int WATCHDOG_NS   = (TABLE_LEN + `HAM_LATENCY + 20) * CLK_PERIOD_NS * 2;

    // zeros, ones, alternating and single-bit words
    localparam data_word_t FIXED_WORDS [N_FIXED] = '{
        26'h0000000, 26'h3FFFFFF, 26'h2AAAAAA, 26'h1555555,
        26'h0000001, 26'h0001000, 26'h2000000, 26'h0F0F0F0
    };

    // word used for the flip sweep over all positions
    localparam data_word_t SWEEP_WORD = 26'h2B3C4D5;

    // one table row per test
    // group 0 is fixed, 1 is sweep and 2 is streaming
    typedef struct packed {
        logic [1:0] group;
        data_word_t data;
        syndrome_t  flip;
        codeword_t  code;
        codeword_t  received;
    } stim_t;

    logic           clk;
    logic           reset;
    data_word_t     data_in;
    codeword_t      received_in;
    codeword_t      encoded_out;
    decode_result_t result;

    stim_t stim_table [TABLE_LEN];
    stim_t pending [$];

    int mismatches   = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    hamming_codec_top i_hamming_codec_top (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .encoded_out (encoded_out),
        .received_in (received_in),
        .result      (result)
    );

    // data into non-power-of-two positions in order
    // parity is the XOR of the numbers of all set data positions
    function automatic codeword_t ref_encode(input data_word_t data);
        codeword_t code;
        syndrome_t par;
        int        k;
        code = '0;
        par = '0;
        k = 0;
        for (int p = 1; p <= `HAM_CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                code[p-1] = data[k];
                if (data[k]) begin
                    par = par ^ syndrome_t'(p);
                end
                k++;
            end
        end
        for (int i = 0; i < `HAM_PARITY_W; i++) begin
            code[(1 << i) - 1] = par[i];
        end
        return code;
    endfunction

    function automatic codeword_t apply_flip(input codeword_t code, input syndrome_t flip);
        codeword_t word;
        word = code;
        if (flip != '0) begin
            word[flip-1] = ~word[flip-1];
        end
        return word;
    endfunction

    function automatic string group_name(input logic [1:0] group);
        case (group)
            2'd0:    return "fixed";
            2'd1:    return "sweep";
            default: return "stream";
        endcase
    endfunction

    task automatic set_entry(input int idx, input data_word_t data, input syndrome_t flip,
                             input logic [1:0] group);
        stim_table[idx].group    = group;
        stim_table[idx].data     = data;
        stim_table[idx].flip     = flip;
        stim_table[idx].code     = ref_encode(data);
        stim_table[idx].received = apply_flip(stim_table[idx].code, flip);
    endtask

    task automatic build_table();
        int idx;
        idx = 0;
        for (int i = 0; i < N_FIXED; i++) begin
            set_entry(idx, FIXED_WORDS[i], '0, 2'd0);
            idx++;
        end
        for (int f = 1; f <= N_SWEEP; f++) begin
            set_entry(idx, SWEEP_WORD, syndrome_t'(f), 2'd1);
            idx++;
        end
        for (int i = 0; i < N_STREAM; i++) begin
            set_entry(idx, data_word_t'($urandom()), syndrome_t'($urandom_range(31, 0)), 2'd2);
            idx++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic finish_test(input string label, input int mismatches_before);
        if (mismatches == mismatches_before) begin
            tests_passed++;
            $display("%s: pass", label);
        end else begin
            tests_failed++;
            $display("%s: FAIL", label);
        end
    endtask

    task automatic check_entry(input stim_t exp, input int num);
        int start_count;
        start_count = mismatches;
        check_value("encoded_out", 32'(exp.code), 32'(encoded_out));
        check_value("result.data", 32'(exp.data), 32'(result.data));
        check_value("result.corrected", 32'(exp.flip != '0), 32'(result.corrected));
        check_value("result.error_pos", 32'(exp.flip), 32'(result.error_pos));
        finish_test($sformatf("test %0d %s data %h flip %0d", num, group_name(exp.group),
                              exp.data, exp.flip), start_count);
    endtask

    initial begin
        int edge_idx;
        int reset_before;
        int checker_failures;
        void'($urandom(SEED));
        data_in = '0;
        received_in = '0;
        build_table();

        // first edge with reset low
        do @(posedge clk); while (reset);
        reset_before = mismatches;

        // a word driven on edge k is checked on edge k + latency + 1
        for (edge_idx = 0; edge_idx < TABLE_LEN + `HAM_LATENCY + 1; edge_idx++) begin
            if (edge_idx > 0) begin
                @(posedge clk);
            end
            if (edge_idx <= `HAM_LATENCY) begin
                check_value("encoded_out", 32'h0, 32'(encoded_out));
                check_value("result.corrected", 32'h0, 32'(result.corrected));
                check_value("result.error_pos", 32'h0, 32'(result.error_pos));
                if (edge_idx == `HAM_LATENCY) begin
                    finish_test("reset state", reset_before);
                end
            end else begin
                check_entry(pending.pop_front(), edge_idx - `HAM_LATENCY - 1);
            end
            if (edge_idx < TABLE_LEN) begin
                data_in     <= stim_table[edge_idx].data;
                received_in <= stim_table[edge_idx].received;
                pending.push_back(stim_table[edge_idx]);
            end
        end

        checker_failures = i_hamming_codec_top.i_codec_checker.assert_failures;
        $display("tests passed %0d failed %0d, checker assertion failures %0d",
                 tests_passed, tests_failed, checker_failures);
        if (tests_failed == 0 && checker_failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/hamming_pkg.sv
logic/codec_status_pkg.sv
logic/hamming_syndrome.sv
logic/hamming_encoder.sv
logic/hamming_decoder.sv
logic/hamming_codec_top.sv
testbench/tb_clock_gen.sv
testbench/hamming_codec_checker.sv
testbench/hamming_codec_tb.sv
